/* bench/mdio_phy_model.sv */
`timescale 1ns/1ps

module mdio_phy_model #(
    parameter logic [4:0] PHY_ADDR = 5'h01
) (
    input  logic mdc,
    input  logic mdio,
    output logic drive_en,
    output logic drive_val
);

    logic [15:0] regs_q [32];
    logic [31:0] frame;
    logic [15:0] rd_sr;
    logic [1:0]  op;
    logic [4:0]  phy;
    logic [4:0]  regn;
    logic        in_frame;
    logic        reading;
    int          ones;
    int          pos;

    initial begin
        for (int i = 0; i < 32; i++) begin
            regs_q[i] = 16'h1000 + 16'(i);
        end
        in_frame  = 1'b0;
        reading   = 1'b0;
        ones      = 0;
        pos       = 0;
        drive_en  = 1'b0;
        drive_val = 1'b1;
    end

    // Frame bits are taken on the rising edge of MDC.
    always @(posedge mdc) begin
        if (!in_frame) begin
            if (mdio) begin
                if (ones < 32) ones++;
            end else if (ones >= 32) begin
                in_frame = 1'b1;
                frame    = 32'd0;
                pos      = 1;
            end else begin
                ones = 0;
            end
        end else begin
            frame = {frame[30:0], mdio};
            pos++;
            if (pos == 14) begin
                op   = frame[11:10];
                phy  = frame[9:5];
                regn = frame[4:0];
                if (op == 2'b10 && phy == PHY_ADDR) begin
                    reading = 1'b1;
                    rd_sr   = regs_q[regn];
                end
            end
            if (pos == 32) begin
                if (op == 2'b01 && phy == PHY_ADDR) begin
                    regs_q[regn] = frame[15:0];
                end
                in_frame = 1'b0;
                reading  = 1'b0;
                ones     = 0;
            end
        end
    end

    // Second turnaround bit is driven low, then the data MSB first.
    always @(negedge mdc) begin
        if (reading && pos == 15) begin
            drive_en  <= 1'b1;
            drive_val <= 1'b0;
        end else if (reading && pos >= 16 && pos <= 31) begin
            drive_en  <= 1'b1;
            drive_val <= rd_sr[15];
            rd_sr = {rd_sr[14:0], 1'b0};
        end else begin
            drive_en  <= 1'b0;
            drive_val <= 1'b1;
        end
    end

endmodule

/* bench/tb_mdio_ctrl.sv */
`timescale 1ns/1ps

module tb_mdio_ctrl import axil_pkg::*, mdio_pkg::*; ();

    typedef struct packed {
        logic [1:0]  op;
        logic [4:0]  phy;
        logic [4:0]  regn;
        logic [15:0] wdata;
        logic [15:0] exp_rdata;
        logic [1:0]  exp_bresp;
    } entry_t;

    logic      clk;
    logic      rst;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic      mdc;
    logic      mdio_o;
    logic      mdio_t;
    logic      mdio_line;
    logic      phy_en;
    logic      phy_val;

    logic [15:0] shadow [32];
    entry_t      stim [7];
    int          errors;
    int          timeouts;

    mdio_ctrl_top #(
        .PRESCALE_INIT(8'd2)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .axil_req(axil_req),
        .mdio_i  (mdio_line),
        .axil_rsp(axil_rsp),
        .mdc     (mdc),
        .mdio_o  (mdio_o),
        .mdio_t  (mdio_t)
    );

    mdio_phy_model #(
        .PHY_ADDR(5'h01)
    ) u_phy (
        .mdc      (mdc),
        .mdio     (mdio_line),
        .drive_en (phy_en),
        .drive_val(phy_val)
    );

    // Open-drain line with a pull-up.
    assign mdio_line = !mdio_t ? mdio_o : (phy_en ? phy_val : 1'b1);

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic rsp_flag(input string what);
        if (what == "awready") begin
            return axil_rsp.awready;
        end else if (what == "bvalid") begin
            return axil_rsp.bvalid;
        end else if (what == "arready") begin
            return axil_rsp.arready;
        end else begin
            return axil_rsp.rvalid;
        end
    endfunction

    task automatic wait_rsp(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!rsp_flag(what) && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!rsp_flag(what)) begin
            $display("Timeout: no %s from the DUT", what);
            timeouts++;
        end
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        axil_req.wvalid  <= 1'b1;
        wait_rsp("awready");
        check("wready", {31'd0, axil_rsp.wready}, 32'd1);
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        wait_rsp("bvalid");
        resp = axil_rsp.bresp;
        // The response waits one cycle before it is accepted.
        @(posedge clk);
        axil_req.bready <= 1'b1;
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        wait_rsp("arready");
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        wait_rsp("rvalid");
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
    endtask

    task automatic wait_idle(output logic [31:0] status);
        logic [1:0] rr;
        int         n;
        n = 0;
        bus_read(REG_STATUS, status, rr);
        while (status[0] && n < 3000) begin
            bus_read(REG_STATUS, status, rr);
            n++;
        end
        if (status[0]) begin
            $display("Timeout: STATUS busy never cleared");
            timeouts++;
        end
    endtask

    // Expected values follow the PHY rules. Only PHY 1 answers and other addresses float high.
    function automatic entry_t make_entry(input logic [1:0] op, input logic [4:0] phy,
                                          input logic [4:0] regn, input logic [15:0] wdata);
        entry_t e;
        e.op        = op;
        e.phy       = phy;
        e.regn      = regn;
        e.wdata     = wdata;
        e.exp_rdata = (phy == 5'h01) ? shadow[regn] : 16'hffff;
        e.exp_bresp = (op == 2'b01 || op == 2'b10) ? AXIL_OKAY : AXIL_SLVERR;
        if (op == 2'b01 && phy == 5'h01 && e.exp_bresp == AXIL_OKAY) begin
            shadow[regn] = wdata;
        end
        return e;
    endfunction

    task automatic run_entry(input entry_t e);
        logic [1:0]  resp;
        logic [31:0] data;
        bus_write(REG_WDATA, {16'd0, e.wdata}, resp);
        check("wdata bresp", {30'd0, resp}, {30'd0, AXIL_OKAY});
        bus_write(REG_CMD, {20'd0, e.op, e.regn, e.phy}, resp);
        check("cmd bresp", {30'd0, resp}, {30'd0, e.exp_bresp});
        if (e.exp_bresp == AXIL_OKAY) begin
            wait_idle(data);
            check("status", data, (e.op == 2'b10) ? 32'd2 : 32'd0);
            if (e.op == 2'b10) begin
                bus_read(REG_RDATA, data, resp);
                check("rdata", data, {16'd0, e.exp_rdata});
            end
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] data;
        logic [1:0]  resp;
        clk      = 1'b0;
        rst      = 1'b1;
        errors   = 0;
        timeouts = 0;
        axil_req = '0;
        axil_req.rready = 1'b1;
        void'($urandom(32'hd14779d5));
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 16'h1000 + 16'(i);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        bus_read(REG_STATUS, data, resp);
        check("status", data, 32'd0);
        bus_read(REG_PRESCALE, data, resp);
        check("prescale", data, 32'd2);
        bus_read(8'h20, data, resp);
        check("undefined rdata", data, 32'd0);
        check("undefined rresp", {30'd0, resp}, {30'd0, AXIL_OKAY});
        check("mdc", {31'd0, mdc}, 32'd0);
        check("mdio_t", {31'd0, mdio_t}, 32'd1);

        stim[0] = make_entry(2'b10, 5'h01, 5'd3, 16'h0000);
        rnd = $urandom();
        stim[1] = make_entry(2'b01, 5'h01, 5'd7, rnd[15:0]);
        stim[2] = make_entry(2'b10, 5'h01, 5'd7, 16'h0000);
        stim[3] = make_entry(2'b10, 5'h05, 5'd2, 16'h0000);
        for (int i = 0; i < 4; i++) begin
            run_entry(stim[i]);
        end

        bus_write(REG_PRESCALE, 32'd6, resp);
        check("prescale bresp", {30'd0, resp}, {30'd0, AXIL_OKAY});
        bus_read(REG_PRESCALE, data, resp);
        check("prescale", data, 32'd6);
        rnd = $urandom();
        stim[4] = make_entry(2'b01, 5'h01, 5'd12, rnd[15:0]);
        stim[5] = make_entry(2'b10, 5'h01, 5'd12, 16'h0000);
        stim[6] = make_entry(2'b00, 5'h01, 5'd1, 16'h0000);
        for (int i = 4; i < 7; i++) begin
            run_entry(stim[i]);
        end

        // RDATA is read-only and keeps the last frame result.
        bus_write(REG_RDATA, 32'h0000_abcd, resp);
        check("rdata bresp", {30'd0, resp}, {30'd0, AXIL_SLVERR});
        bus_read(REG_RDATA, data, resp);
        check("rdata", data, {16'd0, shadow[12]});

        bus_write(REG_CMD, {20'd0, 2'b10, 5'd3, 5'h01}, resp);
        check("cmd bresp", {30'd0, resp}, {30'd0, AXIL_OKAY});
        bus_write(REG_CMD, {20'd0, 2'b01, 5'd9, 5'h01}, resp);
        check("busy cmd bresp", {30'd0, resp}, {30'd0, AXIL_SLVERR});
        wait_idle(data);
        check("status", data, 32'd2);
        bus_read(REG_RDATA, data, resp);
        check("rdata", data, {16'd0, shadow[3]});

        $display("Run finished: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
rtl/axil_pkg.sv
rtl/mdio_pkg.sv
rtl/mdio_regs.sv
rtl/mdio_master.sv
rtl/mdio_ctrl_top.sv
bench/mdio_phy_model.sv
bench/tb_mdio_ctrl.sv

/* rtl/axil_pkg.sv */
package axil_pkg;

    // Master to slave channels of the register bus.
    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // Slave to master channels.
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    localparam logic [1:0] AXIL_OKAY   = 2'b00;
    localparam logic [1:0] AXIL_SLVERR = 2'b10;

endpackage

/* rtl/mdio_ctrl_top.sv */
`timescale 1ns/1ps

module mdio_ctrl_top import axil_pkg::*, mdio_pkg::*; #(
    parameter logic [7:0] PRESCALE_INIT = 8'd4
) (
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t axil_req,
    input  logic      mdio_i,
    output axil_rsp_t axil_rsp,
    output logic      mdc,
    output logic      mdio_o,
    output logic      mdio_t
);

    mdio_cmd_t  mdio_cmd;
    mdio_rsp_t  mdio_rsp;
    logic       cmd_ready;
    logic       master_busy;
    logic [7:0] prescale;

    mdio_regs #(
        .PRESCALE_INIT(PRESCALE_INIT)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .mdio_rsp   (mdio_rsp),
        .cmd_ready  (cmd_ready),
        .master_busy(master_busy),
        .axil_rsp   (axil_rsp),
        .mdio_cmd   (mdio_cmd),
        .prescale   (prescale)
    );

    // Frame engine. The pad itself lives outside the block.
    mdio_master u_master (
        .clk      (clk),
        .rst      (rst),
        .cmd      (mdio_cmd),
        .prescale (prescale),
        .mdio_i   (mdio_i),
        .cmd_ready(cmd_ready),
        .rsp      (mdio_rsp),
        .busy     (master_busy),
        .mdc      (mdc),
        .mdio_o   (mdio_o),
        .mdio_t   (mdio_t)
    );

endmodule

/* rtl/mdio_master.sv */
`timescale 1ns/1ps

module mdio_master import mdio_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  mdio_cmd_t  cmd,
    input  logic [7:0] prescale,
    input  logic       mdio_i,
    output logic       cmd_ready,
    output mdio_rsp_t  rsp,
    output logic       busy,
    output logic       mdc,
    output logic       mdio_o,
    output logic       mdio_t
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_TRANSFER
    } state_e;

    // Counter value on the falling edge that starts the first turnaround bit.
    localparam logic [4:0] TA_BIT = 5'd18;

    state_e      state_q;
    logic [7:0]  cnt_q;
    logic [4:0]  bit_cnt_q;
    logic        mdc_q;
    logic        mdio_o_q;
    logic        mdio_t_q;
    logic        cmd_ready_q;
    logic        rsp_valid_q;
    logic [15:0] rsp_rdata_q;
    logic        is_read_q;
    logic [31:0] sr_q;

    logic cmd_fire;
    logic tick;
    logic mdc_rise;
    logic mdc_fall;
    logic shift_out;
    logic frame_end;

    assign cmd_fire = cmd.valid && cmd_ready_q;
    assign tick     = (state_q != ST_IDLE) && (cnt_q == 8'd0);
    assign mdc_rise = tick && !mdc_q;
    assign mdc_fall = tick && mdc_q;

    // Falling edges that put the next frame bit on the line.
    assign shift_out = mdc_fall &&
                       ((state_q == ST_PREAMBLE && bit_cnt_q == 5'd0) ||
                        (state_q == ST_TRANSFER && bit_cnt_q != 5'd0));
    assign frame_end = mdc_fall && state_q == ST_TRANSFER && bit_cnt_q == 5'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            cnt_q       <= 8'd0;
            bit_cnt_q   <= 5'd0;
            mdc_q       <= 1'b0;
            mdio_o_q    <= 1'b1;
            mdio_t_q    <= 1'b1;
            cmd_ready_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            cmd_ready_q <= (state_q == ST_IDLE) && !cmd_fire;
            rsp_valid_q <= 1'b0;

            // MDC runs only while a frame is in flight.
            if (state_q != ST_IDLE) begin
                if (tick) begin
                    cnt_q <= prescale;
                    mdc_q <= !mdc_q;
                end else begin
                    cnt_q <= cnt_q - 8'd1;
                end
            end

            if (shift_out) begin
                mdio_o_q <= sr_q[31];
            end

            case (state_q)
                ST_IDLE: begin
                    if (cmd_fire) begin
                        state_q   <= ST_PREAMBLE;
                        cnt_q     <= prescale;
                        bit_cnt_q <= 5'd31;
                        mdio_o_q  <= 1'b1;
                        mdio_t_q  <= 1'b0;
                    end
                end
                ST_PREAMBLE: begin
                    if (mdc_fall) begin
                        if (bit_cnt_q == 5'd0) begin
                            state_q   <= ST_TRANSFER;
                            bit_cnt_q <= 5'd31;
                        end else begin
                            bit_cnt_q <= bit_cnt_q - 5'd1;
                        end
                    end
                end
                ST_TRANSFER: begin
                    if (frame_end) begin
                        state_q     <= ST_IDLE;
                        mdio_o_q    <= 1'b1;
                        mdio_t_q    <= 1'b1;
                        rsp_valid_q <= is_read_q;
                    end else if (mdc_fall) begin
                        bit_cnt_q <= bit_cnt_q - 5'd1;
                        if (is_read_q && bit_cnt_q == TA_BIT) begin
                            mdio_t_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end

        // Start, opcode, addresses, turnaround and data, MSB first.
        if (cmd_fire) begin
            sr_q      <= {2'b01, cmd.op, cmd.phy_addr, cmd.reg_addr, 2'b10, cmd.wdata};
            is_read_q <= (cmd.op == MDIO_OP_READ);
        end else if (shift_out) begin
            sr_q <= {sr_q[30:0], 1'b0};
        end else if (mdc_rise && state_q == ST_TRANSFER) begin
            sr_q[0] <= mdio_i;
        end

        if (frame_end) begin
            rsp_rdata_q <= sr_q[15:0];
        end
    end

    assign cmd_ready = cmd_ready_q;
    assign rsp.rdata = rsp_rdata_q;
    assign rsp.valid = rsp_valid_q;
    assign busy      = (state_q != ST_IDLE);
    assign mdc       = mdc_q;
    assign mdio_o    = mdio_o_q;
    assign mdio_t    = mdio_t_q;

    idle_released: assert property (@(posedge clk) disable iff (rst)
        state_q == ST_IDLE |-> mdio_t_q);

    ready_only_idle: assert property (@(posedge clk) disable iff (rst)
        cmd_ready |-> !busy);

endmodule

/* rtl/mdio_pkg.sv */
package mdio_pkg;

    // Clause 22 opcodes. 00 and 11 are never issued.
    typedef enum logic [1:0] {
        MDIO_OP_WRITE = 2'b01,
        MDIO_OP_READ  = 2'b10
    } mdio_op_e;

    typedef struct packed {
        logic [4:0]  phy_addr;
        logic [4:0]  reg_addr;
        mdio_op_e    op;
        logic [15:0] wdata;
        logic        valid;
    } mdio_cmd_t;

    typedef struct packed {
        logic [15:0] rdata;
        logic        valid;
    } mdio_rsp_t;

    // Byte offsets of the controller registers.
    localparam logic [7:0] REG_CMD      = 8'h00;
    localparam logic [7:0] REG_WDATA    = 8'h04;
    localparam logic [7:0] REG_STATUS   = 8'h08;
    localparam logic [7:0] REG_RDATA    = 8'h0C;
    localparam logic [7:0] REG_PRESCALE = 8'h10;

endpackage

/* rtl/mdio_regs.sv */
`timescale 1ns/1ps

module mdio_regs import axil_pkg::*, mdio_pkg::*; #(
    parameter logic [7:0] PRESCALE_INIT = 8'd4
) (
    input  logic       clk,
    input  logic       rst,
    input  axil_req_t  axil_req,
    input  mdio_rsp_t  mdio_rsp,
    input  logic       cmd_ready,
    input  logic       master_busy,
    output axil_rsp_t  axil_rsp,
    output mdio_cmd_t  mdio_cmd,
    output logic [7:0] prescale
);

    logic        wr_ready_q;
    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    mdio_cmd_t   cmd_q;
    logic [15:0] wdata_q;
    logic [7:0]  prescale_q;
    logic        busy_q;
    logic        done_q;
    logic [15:0] rdata_reg_q;

    logic        wr_fire;
    logic        ar_ready;
    logic        ar_fire;
    logic        wr_err;
    logic        cmd_start;
    mdio_op_e    wr_op;
    logic [31:0] rd_mux;

    assign wr_fire  = wr_ready_q && axil_req.awvalid && axil_req.wvalid;
    assign ar_ready = axil_req.arvalid && !rvalid_q;
    assign ar_fire  = ar_ready;
    assign wr_op    = mdio_op_e'(axil_req.wdata[11:10]);

    // Write decode. Read-only registers and bad commands answer SLVERR.
    always_comb begin
        wr_err    = 1'b0;
        cmd_start = 1'b0;
        case (axil_req.awaddr)
            REG_CMD: begin
                if (busy_q || !(wr_op == MDIO_OP_WRITE || wr_op == MDIO_OP_READ)) begin
                    wr_err = 1'b1;
                end else begin
                    cmd_start = 1'b1;
                end
            end
            REG_STATUS, REG_RDATA: wr_err = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        case (axil_req.araddr)
            REG_CMD:      rd_mux = {20'd0, cmd_q.op, cmd_q.reg_addr, cmd_q.phy_addr};
            REG_WDATA:    rd_mux = {16'd0, wdata_q};
            REG_STATUS:   rd_mux = {30'd0, done_q, busy_q};
            REG_RDATA:    rd_mux = {16'd0, rdata_reg_q};
            REG_PRESCALE: rd_mux = {24'd0, prescale_q};
            default:      rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready_q  <= 1'b0;
            bvalid_q    <= 1'b0;
            rvalid_q    <= 1'b0;
            cmd_q.valid <= 1'b0;
            prescale_q  <= PRESCALE_INIT;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            // Address and data are taken together, one cycle after both valids.
            wr_ready_q <= axil_req.awvalid && axil_req.wvalid && !wr_ready_q && !bvalid_q;

            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (bvalid_q && axil_req.bready) begin
                bvalid_q <= 1'b0;
            end

            if (ar_fire) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && axil_req.rready) begin
                rvalid_q <= 1'b0;
            end

            if (wr_fire && axil_req.awaddr == REG_PRESCALE && axil_req.wstrb[0]) begin
                prescale_q <= axil_req.wdata[7:0];
            end

            if (cmd_q.valid && cmd_ready) begin
                cmd_q.valid <= 1'b0;
            end

            if (wr_fire && cmd_start) begin
                cmd_q.valid <= 1'b1;
                busy_q      <= 1'b1;
                done_q      <= 1'b0;
            end else if (busy_q && !cmd_q.valid && !master_busy) begin
                busy_q <= 1'b0;
            end

            if (mdio_rsp.valid) begin
                done_q <= 1'b1;
            end
        end

        if (wr_fire) begin
            bresp_q <= wr_err ? AXIL_SLVERR : AXIL_OKAY;
        end
        if (ar_fire) begin
            rdata_q <= rd_mux;
        end
        if (wr_fire && cmd_start) begin
            cmd_q.phy_addr <= axil_req.wdata[4:0];
            cmd_q.reg_addr <= axil_req.wdata[9:5];
            cmd_q.op       <= wr_op;
            cmd_q.wdata    <= wdata_q;
        end
        if (wr_fire && axil_req.awaddr == REG_WDATA) begin
            if (axil_req.wstrb[0]) begin
                wdata_q[7:0] <= axil_req.wdata[7:0];
            end
            if (axil_req.wstrb[1]) begin
                wdata_q[15:8] <= axil_req.wdata[15:8];
            end
        end
        if (mdio_rsp.valid) begin
            rdata_reg_q <= mdio_rsp.rdata;
        end
    end

    assign axil_rsp.awready = wr_ready_q;
    assign axil_rsp.wready  = wr_ready_q;
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.bvalid  = bvalid_q;
    assign axil_rsp.arready = ar_ready;
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = AXIL_OKAY;
    assign axil_rsp.rvalid  = rvalid_q;

    assign mdio_cmd = cmd_q;
    assign prescale = prescale_q;

    bvalid_held: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));

    cmd_held_stable: assert property (@(posedge clk) disable iff (rst)
        mdio_cmd.valid && !cmd_ready |=> mdio_cmd.valid && $stable(mdio_cmd));

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the MDIO controller testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_mdio_ctrl \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Build or simulation did not complete"

grep -q "TESTBENCH PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
